// File: source/poly_settings.svh
`ifndef POLY_SETTINGS_SVH
`define POLY_SETTINGS_SVH

// coefficient width in bits
`define POLY_WORD_SIZE 16

// data buffer words written by the host
`define POLY_BUFFER_SIZE 1024

// polynomial slots, index A
`define POLY_SLOTS 8

// S words reserved per slot
`define POLY_SLOT_STRIDE 11

// whole S store, slots times stride
`define POLY_S_SIZE (`POLY_SLOTS * `POLY_SLOT_STRIDE)

// degrees above this are rejected
`define POLY_MAX_DEGREE 10

// words per output fifo
`define POLY_FIFO_DEPTH 4

`endif

// File: source/poly_pkg.sv
`include "poly_settings.svh"

package poly_pkg;

	// one coefficient of the data buffer or S store
	typedef logic [`POLY_WORD_SIZE-1:0] coeff_t;

	// degree N as it comes with the instruction, wide enough to hold illegal values
	typedef logic [4:0] degree_t;

	typedef logic [$clog2(`POLY_SLOTS)-1:0] slot_t;        // slot index A
	typedef logic [$clog2(`POLY_BUFFER_SIZE)-1:0] buf_addr_t; // data buffer address
	typedef logic [$clog2(`POLY_S_SIZE)-1:0] s_addr_t;     // S store address

	// result and status fifo word
	typedef logic [31:0] word_t;

	// status codes
	localparam word_t STATUS_OK = 32'd0;
	localparam word_t STATUS_BAD_DEGREE = 32'd2;
	localparam word_t STATUS_RESET = '1;   // nothing run yet

	// result codes
	localparam word_t RESULT_OK = 32'd1;
	localparam word_t RESULT_FAIL = 32'd0;

endpackage

// File: source/coeff_ram.sv
`timescale 1ns/1ps

module coeff_ram
#(
	parameter int DEPTH = 1024,
	parameter type payload_t = logic [15:0]
)
(
	input logic clk,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_addr,
	input payload_t wr_data,
	input logic rd_en,
	input logic [$clog2(DEPTH)-1:0] rd_addr,
	output payload_t rd_data
);

	payload_t mem [DEPTH];   // storage, contents undefined at power up

	// write port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read
	// data shows one cycle after rd_en, held otherwise
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

// File: source/out_fifo.sv
`timescale 1ns/1ps

module out_fifo
#(
	parameter int DEPTH = 4
)
(
	input logic clk,
	input logic rst,
	input logic push,
	input poly_pkg::word_t push_data,
	input logic pop,
	output poly_pkg::word_t pop_data,
	output logic full,
	output logic empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	poly_pkg::word_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;   // words held
	logic do_push;
	logic do_pop;

	assign full = count == CW'(DEPTH);
	assign empty = count == '0;
	assign do_push = push && !full;    // dropped when full
	assign do_pop = pop && !empty;     // dropped when empty

	assign pop_data = mem[rd_ptr];     // head word, no read latency

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// both at once leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: source/stp_fsm.sv
`timescale 1ns/1ps
`include "poly_settings.svh"

module stp_fsm
(
	input logic clk,
	input logic rst,
	input logic start_stp,
	input poly_pkg::slot_t slot,
	input poly_pkg::degree_t degree,
	input poly_pkg::coeff_t rd_data,
	input logic result_full,
	input logic status_full,
	output logic busy,
	output logic done_stp,
	output logic en_rd_data,
	output logic en_wr_s,
	output logic en_wr_n,
	output logic push,
	output poly_pkg::buf_addr_t rd_addr,
	output poly_pkg::s_addr_t wr_addr_s,
	output poly_pkg::coeff_t coeff,
	output poly_pkg::slot_t wr_addr_n,
	output poly_pkg::degree_t n_out,
	output poly_pkg::word_t result,
	output poly_pkg::word_t status
);

	typedef enum logic [2:0]
	{
		ST_IDLE,     // waiting for start_stp
		ST_START,    // degree check
		ST_FIRST_RD, // first buffer read, degree store write
		ST_WRITE,    // one S write per cycle, next read overlapped
		ST_ERROR,    // bad degree, nothing written
		ST_END       // push result and status
	} state_t;

	localparam poly_pkg::s_addr_t STRIDE = poly_pkg::s_addr_t'(`POLY_SLOT_STRIDE);
	localparam poly_pkg::degree_t MAX_DEG = poly_pkg::degree_t'(`POLY_MAX_DEGREE);

	state_t state;
	state_t next_state;

	poly_pkg::slot_t slot_q;      // A held for the whole instruction
	poly_pkg::degree_t degree_q;  // N held for the whole instruction
	poly_pkg::buf_addr_t ptr;     // next unread buffer word
	poly_pkg::degree_t idx;       // coefficient index within the slot
	poly_pkg::word_t result_q;
	poly_pkg::word_t status_q;

	logic room;        // both fifos can take a word
	logic bad_degree;
	logic last;        // writing coefficient N
	poly_pkg::s_addr_t base_s;

	assign room = !result_full && !status_full;
	assign bad_degree = degree_q > MAX_DEG;
	assign last = idx == degree_q;
	assign base_s = poly_pkg::s_addr_t'(slot_q) * STRIDE;   // A*11

	// next state
	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (start_stp)
					next_state = ST_START;
			ST_START:
				next_state = bad_degree ? ST_ERROR : ST_FIRST_RD;
			ST_FIRST_RD:
				next_state = ST_WRITE;
			ST_WRITE:
				if (last)
					next_state = ST_END;
			ST_ERROR:
				next_state = ST_END;
			ST_END:
				if (room)   // stall here while a fifo is full
					next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= ST_IDLE;
			slot_q <= '0;
			degree_q <= '0;
			ptr <= '0;
			idx <= '0;
			result_q <= poly_pkg::RESULT_FAIL;
			status_q <= poly_pkg::STATUS_RESET;
		end
		else
		begin
			state <= next_state;
			case (state)
				ST_IDLE:
					if (start_stp)
					begin
						slot_q <= slot;      // sampled only on accept
						degree_q <= degree;
						idx <= '0;
					end
				ST_START:
					if (bad_degree)
					begin
						result_q <= poly_pkg::RESULT_FAIL;
						status_q <= poly_pkg::STATUS_BAD_DEGREE;
					end
					else
					begin
						result_q <= poly_pkg::RESULT_OK;
						status_q <= poly_pkg::STATUS_OK;
					end
				ST_WRITE:
					if (last)
						ptr <= ptr + poly_pkg::buf_addr_t'(degree_q) + 1'b1;  // consume N+1
					else
						idx <= idx + 1'b1;
				default:
					;
			endcase
		end
	end

	// status outputs
	assign busy = state != ST_IDLE;
	assign done_stp = (state == ST_END) && room;
	assign push = done_stp;   // one strobe for both fifos

	// buffer read port
	// first read takes ptr, each write cycle fetches the word after it
	assign en_rd_data = (state == ST_FIRST_RD) || ((state == ST_WRITE) && !last);
	assign rd_addr = ptr + poly_pkg::buf_addr_t'(idx)
		+ poly_pkg::buf_addr_t'(state == ST_WRITE);

	// S write port, word idx of the slot
	assign en_wr_s = state == ST_WRITE;
	assign wr_addr_s = base_s + poly_pkg::s_addr_t'(idx);
	assign coeff = rd_data;   // read data lands one cycle after its request

	// degree store, written once per legal instruction
	assign en_wr_n = state == ST_FIRST_RD;
	assign wr_addr_n = slot_q;
	assign n_out = degree_q;

	assign result = result_q;
	assign status = status_q;

endmodule

// File: source/poly_top.sv
`timescale 1ns/1ps
`include "poly_settings.svh"

module poly_top
(
	input logic clk,
	input logic rst,
	input logic buf_wr_en,
	input poly_pkg::buf_addr_t buf_wr_addr,
	input poly_pkg::coeff_t buf_wr_data,
	input logic start_stp,
	input poly_pkg::slot_t slot,
	input poly_pkg::degree_t degree,
	input poly_pkg::s_addr_t s_rd_addr,
	output poly_pkg::coeff_t s_rd_data,
	input poly_pkg::slot_t n_rd_addr,
	output poly_pkg::degree_t n_rd_data,
	input logic result_pop,
	output poly_pkg::word_t result_data,
	output logic result_empty,
	input logic status_pop,
	output poly_pkg::word_t status_data,
	output logic status_empty,
	output logic busy
);

	// buffer read side
	logic en_rd_data;
	poly_pkg::buf_addr_t rd_addr;
	poly_pkg::coeff_t rd_data;

	// S and degree store write side
	logic en_wr_s;
	poly_pkg::s_addr_t wr_addr_s;
	poly_pkg::coeff_t coeff;
	logic en_wr_n;
	poly_pkg::slot_t wr_addr_n;
	poly_pkg::degree_t n_out;

	// fifo side
	logic push;
	poly_pkg::word_t result;
	poly_pkg::word_t status;
	logic result_full;
	logic status_full;

	// data buffer written by the host and read by the controller
	coeff_ram #(.DEPTH(`POLY_BUFFER_SIZE), .payload_t(poly_pkg::coeff_t)) buf_ram_i
	(
		.clk(clk),
		.wr_en(buf_wr_en),
		.wr_addr(buf_wr_addr),
		.wr_data(buf_wr_data),
		.rd_en(en_rd_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	// coefficient store S read back by the host
	coeff_ram #(.DEPTH(`POLY_S_SIZE), .payload_t(poly_pkg::coeff_t)) s_ram_i
	(
		.clk(clk),
		.wr_en(en_wr_s),
		.wr_addr(wr_addr_s),
		.wr_data(coeff),
		.rd_en(1'b1),
		.rd_addr(s_rd_addr),
		.rd_data(s_rd_data)
	);

	// degree store with one entry per slot
	coeff_ram #(.DEPTH(`POLY_SLOTS), .payload_t(poly_pkg::degree_t)) n_ram_i
	(
		.clk(clk),
		.wr_en(en_wr_n),
		.wr_addr(wr_addr_n),
		.wr_data(n_out),
		.rd_en(1'b1),
		.rd_addr(n_rd_addr),
		.rd_data(n_rd_data)
	);

	stp_fsm stp_fsm_i
	(
		.clk(clk),
		.rst(rst),
		.start_stp(start_stp),
		.slot(slot),
		.degree(degree),
		.rd_data(rd_data),
		.result_full(result_full),
		.status_full(status_full),
		.busy(busy),
		.done_stp(),
		.en_rd_data(en_rd_data),
		.en_wr_s(en_wr_s),
		.en_wr_n(en_wr_n),
		.push(push),
		.rd_addr(rd_addr),
		.wr_addr_s(wr_addr_s),
		.coeff(coeff),
		.wr_addr_n(wr_addr_n),
		.n_out(n_out),
		.result(result),
		.status(status)
	);

	// result and status share the push strobe
	out_fifo #(.DEPTH(`POLY_FIFO_DEPTH)) result_fifo_i
	(
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_data(result),
		.pop(result_pop),
		.pop_data(result_data),
		.full(result_full),
		.empty(result_empty)
	);

	out_fifo #(.DEPTH(`POLY_FIFO_DEPTH)) status_fifo_i
	(
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_data(status),
		.pop(status_pop),
		.pop_data(status_data),
		.full(status_full),
		.empty(status_empty)
	);

endmodule

// File: verification/tb_poly_top.sv
`timescale 1ns/1ps
`include "poly_settings.svh"

module tb_poly_top;

	localparam int MAX_LINES = 64;
	localparam int CYCLES_PER_CMD = 200;

	logic clk;
	logic rst;
	logic buf_wr_en;
	poly_pkg::buf_addr_t buf_wr_addr;
	poly_pkg::coeff_t buf_wr_data;
	logic start_stp;
	poly_pkg::slot_t slot;
	poly_pkg::degree_t degree;
	poly_pkg::s_addr_t s_rd_addr;
	poly_pkg::coeff_t s_rd_data;
	poly_pkg::slot_t n_rd_addr;
	poly_pkg::degree_t n_rd_data;
	logic result_pop;
	poly_pkg::word_t result_data;
	logic result_empty;
	logic status_pop;
	poly_pkg::word_t status_data;
	logic status_empty;
	logic busy;

	logic [31:0] stim [MAX_LINES*5];   // five hex fields per line
	int n_cmds;

	// reference model of the stores and the pointer
	poly_pkg::coeff_t buf_m [`POLY_BUFFER_SIZE];
	poly_pkg::coeff_t s_m [`POLY_S_SIZE];
	bit s_known [`POLY_S_SIZE];
	poly_pkg::degree_t n_m [`POLY_SLOTS];
	bit n_known [`POLY_SLOTS];
	int ptr_m;

	poly_pkg::word_t exp_result [$];   // issue order
	poly_pkg::word_t exp_status [$];
	bit pop_en;
	logic [15:0] lfsr;

	poly_top dut_i
	(
		.clk(clk), .rst(rst),
		.buf_wr_en(buf_wr_en), .buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data),
		.start_stp(start_stp), .slot(slot), .degree(degree),
		.s_rd_addr(s_rd_addr), .s_rd_data(s_rd_data),
		.n_rd_addr(n_rd_addr), .n_rd_data(n_rd_data),
		.result_pop(result_pop), .result_data(result_data), .result_empty(result_empty),
		.status_pop(status_pop), .status_data(status_data), .status_empty(status_empty),
		.busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// pipelined readback with the data for address i checked one cycle later
	task automatic check_stores(input string name);
		for (int i = 0; i <= `POLY_S_SIZE; i++)
		begin
			@(negedge clk);
			if (i > 0 && s_known[i-1])
				assert (s_rd_data === s_m[i-1])
				else fail_run($sformatf("CHECK FAILED %s s[%0d] expected %h actual %h",
					name, i - 1, s_m[i-1], s_rd_data));
			if (i < `POLY_S_SIZE)
				s_rd_addr = poly_pkg::s_addr_t'(i);
		end
		for (int i = 0; i <= `POLY_SLOTS; i++)
		begin
			@(negedge clk);
			if (i > 0 && n_known[i-1])
				assert (n_rd_data === n_m[i-1])
				else fail_run($sformatf("CHECK FAILED %s n[%0d] expected %h actual %h",
					name, i - 1, n_m[i-1], n_rd_data));
			if (i < `POLY_SLOTS)
				n_rd_addr = poly_pkg::slot_t'(i);
		end
	endtask

	task automatic run_stp(input int line, input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] res, input logic [31:0] stat, input bit stall);
		poly_pkg::slot_t sl;
		poly_pkg::degree_t dg;
		string name;
		sl = poly_pkg::slot_t'(a);
		dg = poly_pkg::degree_t'(b);
		name = $sformatf("stp line %0d", line);
		assert (!busy)
		else fail_run($sformatf("CHECK FAILED %s busy at issue expected 0 actual %b",
			name, busy));
		exp_result.push_back(res);
		exp_status.push_back(stat);
		@(negedge clk);
		start_stp = 1'b1;
		slot = sl;
		degree = dg;
		@(negedge clk);
		start_stp = 1'b0;
		slot = ~sl;     // must not reach the stores
		degree = '0;
		@(negedge clk);
		assert (busy)
		else fail_run($sformatf("CHECK FAILED %s busy after start expected 1 actual %b",
			name, busy));
		start_stp = 1'b1;   // ignored while busy
		@(negedge clk);
		start_stp = 1'b0;
		if (stall)
		begin
			repeat (30)
			begin
				@(negedge clk);
				assert (busy)
				else fail_run($sformatf("CHECK FAILED %s busy while stalled expected 1 actual %b",
					name, busy));
			end
			assert (!result_empty && !status_empty)
			else fail_run($sformatf("CHECK FAILED %s empty flags expected 00 actual %b%b",
				name, result_empty, status_empty));
			pop_en = 1'b1;
		end
		while (busy)
			@(negedge clk);   // wait for the instruction to end
		if (dg <= `POLY_MAX_DEGREE)
		begin
			for (int i = 0; i <= dg; i++)
			begin
				s_m[sl * `POLY_SLOT_STRIDE + i] = buf_m[(ptr_m + i) % `POLY_BUFFER_SIZE];
				s_known[sl * `POLY_SLOT_STRIDE + i] = 1'b1;
			end
			n_m[sl] = dg;
			n_known[sl] = 1'b1;
			ptr_m = (ptr_m + dg + 1) % `POLY_BUFFER_SIZE;
		end
		check_stores(name);
	endtask

	// pops both fifos after an lfsr picked delay and checks the head words
	initial
	begin : popper
		int delay;
		result_pop = 1'b0;
		status_pop = 1'b0;
		forever
		begin
			@(negedge clk);
			result_pop = 1'b0;
			status_pop = 1'b0;
			if (pop_en && !result_empty)
			begin
				delay = 0;
				repeat (2)
				begin
					lfsr = lfsr_next(lfsr);
					delay = (delay << 1) | lfsr[0];   // one step per bit
				end
				repeat (delay) @(negedge clk);
				assert (exp_result.size() > 0)
				else fail_run("a result word appeared that no command issued");
				assert (!status_empty)
				else fail_run($sformatf("CHECK FAILED pop status_empty expected 0 actual %b",
					status_empty));
				assert (result_data === exp_result[0])
				else fail_run($sformatf("CHECK FAILED result fifo expected %h actual %h",
					exp_result[0], result_data));
				assert (status_data === exp_status[0])
				else fail_run($sformatf("CHECK FAILED status fifo expected %h actual %h",
					exp_status[0], status_data));
				void'(exp_result.pop_front());
				void'(exp_status.pop_front());
				result_pop = 1'b1;
				status_pop = 1'b1;
			end
		end
	end

	initial
	begin : watchdog
		@(posedge clk);   // line count is settled by now
		repeat ((n_cmds + 1) * CYCLES_PER_CMD) @(posedge clk);
		fail_run("watchdog timeout, the commands did not finish in time");
	end

	initial
	begin : main
		logic [31:0] cmd;
		int line;
		rst = 1'b0;
		buf_wr_en = 1'b0;
		buf_wr_addr = '0;
		buf_wr_data = '0;
		start_stp = 1'b0;
		slot = '0;
		degree = '0;
		s_rd_addr = '0;
		n_rd_addr = '0;
		pop_en = 1'b1;
		lfsr = 16'd29569;
		ptr_m = 0;
		n_cmds = 0;
		$readmemh("verification/stp_input.txt", stim);
		while (n_cmds < MAX_LINES && stim[n_cmds*5] !== 32'hf)
			n_cmds++;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		assert (!busy && result_empty && status_empty)
		else fail_run($sformatf("CHECK FAILED reset busy/empty expected 011 actual %b%b%b",
			busy, result_empty, status_empty));
		// background pattern over the low buffer words
		for (int i = 0; i < 64; i++)
		begin
			buf_wr_en = 1'b1;
			buf_wr_addr = poly_pkg::buf_addr_t'(i);
			buf_wr_data = {buf_wr_addr[5:0], buf_wr_addr} ^ 16'h3c00;
			buf_m[i] = buf_wr_data;
			@(negedge clk);
		end
		buf_wr_en = 1'b0;
		for (line = 0; line < n_cmds; line++)
		begin
			cmd = stim[line*5];
			case (cmd)
				0:
				begin
					buf_wr_en = 1'b1;
					buf_wr_addr = poly_pkg::buf_addr_t'(stim[line*5+1]);
					buf_wr_data = poly_pkg::coeff_t'(stim[line*5+2]);
					buf_m[buf_wr_addr] = buf_wr_data;
					@(negedge clk);
					buf_wr_en = 1'b0;
				end
				1, 3:
					run_stp(line, stim[line*5+1], stim[line*5+2], stim[line*5+3],
						stim[line*5+4], cmd == 3);
				2:
				begin
					if (stim[line*5+1] == 0)
						while (exp_result.size() > 0)
							@(negedge clk);   // drain before holding pops
					pop_en = stim[line*5+1] != 0;
				end
				default:
					fail_run($sformatf("unknown command %h in the input file", cmd));
			endcase
		end
		pop_en = 1'b1;
		while (exp_result.size() > 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (result_empty && status_empty)
		else fail_run($sformatf("CHECK FAILED drain empty flags expected 11 actual %b%b",
			result_empty, status_empty));
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: verification/stp_input.txt
// cmd a b c d in hex. cmd 0 buffer write, a address, b word
// cmd 1 stp, a slot, b degree, c result, d status. cmd 2 a=0 holds pops. cmd 3 stp into full fifos
0 000 beef 0 0
0 004 1234 0 0
1 0 0 1 0    // n=0 from word 0
1 3 a 1 0    // n=10, words 1..11
1 3 b 0 2    // illegal, slot 3 kept
1 5 1f 0 2
1 5 2 1 0    // pointer still at 12
2 0 0 0 0
1 1 1 1 0
1 2 3 1 0
1 6 0 1 0
1 7 4 1 0    // fifos now full
3 4 2 1 0
1 0 5 1 0
f 0 0 0 0

// File: flist.f
+incdir+source
source/poly_pkg.sv
source/coeff_ram.sv
source/out_fifo.sv
source/stp_fsm.sv
source/poly_top.sv
verification/tb_poly_top.sv

// File: Bender.yml
package:
  name: poly_stp

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/poly_pkg.sv
      - source/coeff_ram.sv
      - source/out_fifo.sv
      - source/stp_fsm.sv
      - source/poly_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_poly_top.sv
